// File: rtl/snes_load_pkg.sv
package snes_load_pkg;

  // header size code, rom or save ram, 1 KiB << code
  typedef logic [3:0] size_code_t;

  // cartridge address mask, 24-bit bus space
  typedef logic [23:0] addr_mask_t;

  // clear sweep address
  // sized for the largest cleared ram (wram, 128 KiB)
  typedef logic [16:0] fill_addr_t;

  // one byte of ram data
  typedef logic [7:0] mem_byte_t;

  // start-up fill pattern select
  typedef logic [1:0] fill_sel_t;

  // download / settle tracking
  typedef enum logic [1:0] {
    load_idle,
    load_active,
    load_settle
  } load_state_t;

  // cycles from download end to mask update
  // gives the header parser time to post its size codes
  localparam int SETTLE_CYCLES = 6;

  // settle counter width, counts SETTLE_CYCLES-1 down to 0
  localparam int SETTLE_W = $clog2(SETTLE_CYCLES);

  // size code 0 means 1 KiB
  localparam int MASK_BASE_SHIFT = 10;

  // quarter-rate divider width
  localparam int PHASE_W = 2;

endpackage

// File: rtl/load_sequencer.sv
`timescale 1ns/1ps

module load_sequencer (
  input  logic                    clk_sys,
  input  logic                    reset,
  input  logic                    cart_download,
  input  snes_load_pkg::size_code_t rom_size,
  input  snes_load_pkg::size_code_t ram_size,
  output logic                    load_start,
  output logic                    load_busy,
  output snes_load_pkg::addr_mask_t rom_mask,
  output snes_load_pkg::addr_mask_t ram_mask,
  output snes_load_pkg::size_code_t sram_size
);

  import snes_load_pkg::*;

  load_state_t         state;
  logic                download_q;
  logic [SETTLE_W-1:0] settle_cnt;

  // (1 KiB << code) - 1, wraps to all ones past the 24-bit space
  function automatic addr_mask_t size_to_mask(input size_code_t code);
    return (addr_mask_t'(1) << (MASK_BASE_SHIFT + int'(code))) - addr_mask_t'(1);
  endfunction

  // rising edge of the download level
  assign load_start = cart_download & ~download_q;

  // core held off from first download cycle until masks are valid
  assign load_busy = (state != load_idle);

  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      state      <= load_idle;
      download_q <= 1'b0;
      settle_cnt <= '0;
      rom_mask   <= '0;
      ram_mask   <= '0;
      sram_size  <= '0;
    end else begin
      download_q <= cart_download;
      case (state)
        load_idle: begin
          if (cart_download) begin
            state <= load_active;
          end
        end
        load_active: begin
          // first low sample, start the settle countdown
          if (!cart_download) begin
            state      <= load_settle;
            settle_cnt <= SETTLE_W'(SETTLE_CYCLES - 1);
          end
        end
        load_settle: begin
          if (cart_download) begin
            // new download, drop this update
            state <= load_active;
          end else if (settle_cnt == '0) begin
            state     <= load_idle;
            rom_mask  <= size_to_mask(rom_size);
            // no save ram at all when code is zero
            ram_mask  <= (ram_size == '0) ? '0 : size_to_mask(ram_size);
            sram_size <= ram_size;
          end else begin
            settle_cnt <= settle_cnt - 1'b1;
          end
        end
        default: begin
          state <= load_idle;
        end
      endcase
    end
  end

endmodule

// File: rtl/ram_clear.sv
`timescale 1ns/1ps

module ram_clear (
  input  logic                     clk_sys,
  input  logic                     reset,
  input  logic                     load_start,
  input  snes_load_pkg::fill_sel_t wram_fill_sel,
  input  snes_load_pkg::fill_sel_t aram_fill_sel,
  output logic                     clearing,
  output snes_load_pkg::fill_addr_t fill_addr,
  output snes_load_pkg::mem_byte_t wram_fill_data,
  output snes_load_pkg::mem_byte_t aram_fill_data
);

  import snes_load_pkg::*;

  // fill bytes, chosen to mimic real console power-up contents
  localparam mem_byte_t PAT_STRIPE_HI = 8'h66;
  localparam mem_byte_t PAT_STRIPE_LO = 8'h99;
  localparam mem_byte_t PAT_ONES      = 8'hFF;
  localparam mem_byte_t PAT_ZEROS     = 8'h00;
  localparam mem_byte_t PAT_ALT       = 8'h55;

  logic [PHASE_W-1:0] phase;

  // pattern byte for one address, same rule for wram and aram
  function automatic mem_byte_t fill_byte(input fill_sel_t sel, input fill_addr_t addr);
    mem_byte_t data;
    case (sel)
      2'd0: data = (addr[8] ^ addr[2]) ? PAT_STRIPE_HI : PAT_STRIPE_LO;
      2'd1: data = (addr[9] ^ addr[0]) ? PAT_ONES : PAT_ZEROS;
      2'd2: data = PAT_ALT;
      default: data = PAT_ONES;
    endcase
    return data;
  endfunction

  assign wram_fill_data = fill_byte(wram_fill_sel, fill_addr);
  assign aram_fill_data = fill_byte(aram_fill_sel, fill_addr);

  // quarter rate, psram writes need the slack
  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      phase <= '0;
    end else begin
      phase <= phase + 1'b1;
    end
  end

  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      clearing  <= 1'b0;
      fill_addr <= '0;
    end else if (load_start) begin
      // a fresh download always restarts the sweep from the bottom
      clearing  <= 1'b1;
      fill_addr <= '0;
    end else if (clearing) begin
      if (&fill_addr) begin
        // top address written, sweep done
        clearing  <= 1'b0;
        fill_addr <= '0;
      end else if (phase == '0) begin
        fill_addr <= fill_addr + 1'b1;
      end
    end else begin
      fill_addr <= '0;
    end
  end

endmodule

// File: rtl/core_reset_gen.sv
`timescale 1ns/1ps

module core_reset_gen (
  input  logic clk_sys,
  input  logic reset,
  input  logic hold,
  output logic core_reset_n,
  output logic refresh
);

  import snes_load_pkg::*;

  // free-running four-phase divider
  logic [PHASE_W-1:0] div;

  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      div          <= '0;
      refresh      <= 1'b0;
      core_reset_n <= 1'b0;
    end else begin
      div <= div + 1'b1;
      // one refresh slot per divider turn
      refresh <= (div == '0);
      // core reset only moves at phase two
      // keeps the release aligned to the memory slots
      if (div == PHASE_W'(2)) begin
        core_reset_n <= ~hold;
      end
    end
  end

endmodule

// File: rtl/snes_load_top.sv
`timescale 1ns/1ps

module snes_load_top (
  input  logic                      clk_sys,
  input  logic                      reset,
  input  logic                      cart_download,
  input  logic                      core_reset_req,
  input  snes_load_pkg::size_code_t rom_size,
  input  snes_load_pkg::size_code_t ram_size,
  input  snes_load_pkg::fill_sel_t  wram_fill_sel,
  input  snes_load_pkg::fill_sel_t  aram_fill_sel,
  output snes_load_pkg::addr_mask_t rom_mask,
  output snes_load_pkg::addr_mask_t ram_mask,
  output snes_load_pkg::size_code_t sram_size,
  output logic                      clearing,
  output snes_load_pkg::fill_addr_t fill_addr,
  output snes_load_pkg::mem_byte_t  wram_fill_data,
  output snes_load_pkg::mem_byte_t  aram_fill_data,
  output logic                      core_reset_n,
  output logic                      refresh
);

  logic load_start;
  logic load_busy;
  logic core_hold;

  // anything still loading or clearing keeps the core in reset
  assign core_hold = core_reset_req | load_busy | clearing;

  load_sequencer u_load (
    .clk_sys       (clk_sys),
    .reset         (reset),
    .cart_download (cart_download),
    .rom_size      (rom_size),
    .ram_size      (ram_size),
    .load_start    (load_start),
    .load_busy     (load_busy),
    .rom_mask      (rom_mask),
    .ram_mask      (ram_mask),
    .sram_size     (sram_size)
  );

  ram_clear u_clear (
    .clk_sys        (clk_sys),
    .reset          (reset),
    .load_start     (load_start),
    .wram_fill_sel  (wram_fill_sel),
    .aram_fill_sel  (aram_fill_sel),
    .clearing       (clearing),
    .fill_addr      (fill_addr),
    .wram_fill_data (wram_fill_data),
    .aram_fill_data (aram_fill_data)
  );

  core_reset_gen u_rst (
    .clk_sys      (clk_sys),
    .reset        (reset),
    .hold         (core_hold),
    .core_reset_n (core_reset_n),
    .refresh      (refresh)
  );

endmodule

// File: dv/snes_load_props.sv
`timescale 1ns/1ps

module snes_load_props (
  input logic                      clk_sys,
  input logic                      reset,
  input logic                      load_start,
  input logic                      load_busy,
  input logic                      clearing,
  input snes_load_pkg::fill_addr_t fill_addr,
  input logic                      core_reset_n,
  input logic                      refresh
);

  import snes_load_pkg::*;

  // cycles since reset release
  // saturates at 8
  logic [3:0] run_cnt;
  logic       armed;
  // last four samples of busy or clearing
  logic [3:0] hold_hist;

  assign armed = (run_cnt == 4'd8);

  always_ff @(posedge clk_sys) begin
    if (!reset) begin
      run_cnt   <= '0;
      hold_hist <= '0;
    end else begin
      if (!armed) begin
        run_cnt <= run_cnt + 4'd1;
      end
      hold_hist <= {hold_hist[2:0], load_busy | clearing};
    end
  end

  // any four consecutive cycles hold exactly one refresh
  a_refresh_period: assert property (@(posedge clk_sys) disable iff (!armed)
    $onehot({refresh, $past(refresh, 1), $past(refresh, 2), $past(refresh, 3)}))
    else $error("refresh is not high once in every four cycles");

  // sweep address holds or steps by one outside a restart
  a_fill_step: assert property (@(posedge clk_sys) disable iff (!reset)
    (clearing && $past(clearing) && !$past(load_start)) |->
      (fill_addr == $past(fill_addr) || fill_addr == fill_addr_t'($past(fill_addr) + 1'b1)))
    else $error("fill_addr jumped during the sweep");

  // four busy samples cover one phase-two slot
  a_core_held: assert property (@(posedge clk_sys) disable iff (!reset)
    (&hold_hist) |-> !core_reset_n)
    else $error("core_reset_n released while loading or clearing");

  // single-cycle start that opens the sweep
  a_start_pulse: assert property (@(posedge clk_sys) disable iff (!reset)
    load_start |=> (!load_start && clearing))
    else $error("load_start is not a one-cycle pulse that starts the sweep");

endmodule

bind snes_load_top snes_load_props u_props (
  .clk_sys      (clk_sys),
  .reset        (reset),
  .load_start   (load_start),
  .load_busy    (load_busy),
  .clearing     (clearing),
  .fill_addr    (fill_addr),
  .core_reset_n (core_reset_n),
  .refresh      (refresh)
);

// File: dv/tb_snes_load.sv
`timescale 1ns/1ps

module tb_snes_load;

  import snes_load_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int DRIVE_DELAY = 2;
  localparam int EPISODES    = 4;
  // one sweep is 2^17 steps of 4 cycles
  localparam longint WATCHDOG_NS = longint'(EPISODES) * 600000 * CLK_PERIOD;

  logic       clk_sys;
  logic       reset;
  logic       cart_download;
  logic       core_reset_req;
  size_code_t rom_size;
  size_code_t ram_size;
  fill_sel_t  wram_fill_sel;
  fill_sel_t  aram_fill_sel;
  addr_mask_t rom_mask;
  addr_mask_t ram_mask;
  size_code_t sram_size;
  logic       clearing;
  fill_addr_t fill_addr;
  mem_byte_t  wram_fill_data;
  mem_byte_t  aram_fill_data;
  logic       core_reset_n;
  logic       refresh;

  integer seed;
  logic   check_en;

  // model state
  logic       exp_dl_prev;
  logic       exp_loading;
  logic       exp_settling;
  int         exp_settle_left;
  addr_mask_t exp_rom_mask;
  addr_mask_t exp_ram_mask;
  size_code_t exp_sram_size;
  logic       exp_clearing;
  fill_addr_t exp_addr;
  logic [1:0] exp_div;
  logic       exp_refresh;
  logic       exp_core_reset_n;

  snes_load_top dut0 (
    .clk_sys        (clk_sys),
    .reset          (reset),
    .cart_download  (cart_download),
    .core_reset_req (core_reset_req),
    .rom_size       (rom_size),
    .ram_size       (ram_size),
    .wram_fill_sel  (wram_fill_sel),
    .aram_fill_sel  (aram_fill_sel),
    .rom_mask       (rom_mask),
    .ram_mask       (ram_mask),
    .sram_size      (sram_size),
    .clearing       (clearing),
    .fill_addr      (fill_addr),
    .wram_fill_data (wram_fill_data),
    .aram_fill_data (aram_fill_data),
    .core_reset_n   (core_reset_n),
    .refresh        (refresh)
  );

  initial begin
    clk_sys = 1'b0;
    forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: episodes still running after %0d ns", WATCHDOG_NS);
    abort_run();
  end

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic mask_check(input string name, input addr_mask_t exp, input addr_mask_t act);
    if (act !== exp) begin
      $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic size_check(input string name, input size_code_t exp, input size_code_t act);
    if (act !== exp) begin
      $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic addr_check(input string name, input fill_addr_t exp, input fill_addr_t act);
    if (act !== exp) begin
      $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic byte_check(input string name, input mem_byte_t exp, input mem_byte_t act);
    if (act !== exp) begin
      $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic bit_check(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  // (1 KiB << code) - 1 kept to the low 24 bits
  function automatic addr_mask_t mask_for(input size_code_t code, input logic zero_is_none);
    logic [31:0] span;
    span = 32'd1 << (MASK_BASE_SHIFT + int'(code));
    if (zero_is_none && code == 4'd0) begin
      return '0;
    end
    return addr_mask_t'(span - 32'd1);
  endfunction

  // expected start-up byte
  function automatic mem_byte_t fill_for(input fill_sel_t sel, input fill_addr_t addr);
    mem_byte_t val;
    val = 8'hFF;
    if (sel == 2'd0) begin
      val = (addr[8] != addr[2]) ? 8'h66 : 8'h99;
    end else if (sel == 2'd1) begin
      val = (addr[9] != addr[0]) ? 8'hFF : 8'h00;
    end else if (sel == 2'd2) begin
      val = 8'h55;
    end
    return val;
  endfunction

  // cycle-level model of the whole block
  // inputs are stable at the edge
  always @(posedge clk_sys) begin : model_step
    logic start;
    logic hold;
    if (!reset) begin
      exp_dl_prev      = 1'b0;
      exp_loading      = 1'b0;
      exp_settling     = 1'b0;
      exp_settle_left  = 0;
      exp_rom_mask     = '0;
      exp_ram_mask     = '0;
      exp_sram_size    = '0;
      exp_clearing     = 1'b0;
      exp_addr         = '0;
      exp_div          = 2'd0;
      exp_refresh      = 1'b0;
      exp_core_reset_n = 1'b0;
    end else begin
      start = cart_download && !exp_dl_prev;
      hold  = core_reset_req || exp_loading || exp_settling || exp_clearing;
      // refresh one cycle after phase zero
      exp_refresh = (exp_div == 2'd0);
      // reset moves only at phase two
      if (exp_div == 2'd2) begin
        exp_core_reset_n = !hold;
      end
      // sweep steps once per divider turn
      if (start) begin
        exp_clearing = 1'b1;
        exp_addr     = '0;
      end else if (exp_clearing && exp_addr == '1) begin
        exp_clearing = 1'b0;
        exp_addr     = '0;
      end else if (exp_clearing && exp_div == 2'd0) begin
        exp_addr = exp_addr + fill_addr_t'(1);
      end
      // download end starts the settle countdown
      if (cart_download) begin
        exp_loading  = 1'b1;
        exp_settling = 1'b0;
      end else if (exp_loading) begin
        exp_loading     = 1'b0;
        exp_settling    = 1'b1;
        exp_settle_left = SETTLE_CYCLES;
      end else if (exp_settling) begin
        exp_settle_left = exp_settle_left - 1;
        if (exp_settle_left == 0) begin
          exp_settling  = 1'b0;
          exp_rom_mask  = mask_for(rom_size, 1'b0);
          exp_ram_mask  = mask_for(ram_size, 1'b1);
          exp_sram_size = ram_size;
        end
      end
      exp_div     = exp_div + 2'd1;
      exp_dl_prev = cart_download;
    end
  end

  // every output against the model once per cycle
  always @(negedge clk_sys) begin
    if (check_en) begin
      mask_check("rom_mask", exp_rom_mask, rom_mask);
      mask_check("ram_mask", exp_ram_mask, ram_mask);
      size_check("sram_size", exp_sram_size, sram_size);
      bit_check("clearing", exp_clearing, clearing);
      addr_check("fill_addr", exp_addr, fill_addr);
      byte_check("wram_fill_data", fill_for(wram_fill_sel, exp_addr), wram_fill_data);
      byte_check("aram_fill_data", fill_for(aram_fill_sel, exp_addr), aram_fill_data);
      bit_check("core_reset_n", exp_core_reset_n, core_reset_n);
      bit_check("refresh", exp_refresh, refresh);
    end
  end

  task automatic step_cycle();
    @(posedge clk_sys);
    #(DRIVE_DELAY);
  endtask

  task automatic drive_download(input int len);
    cart_download = 1'b1;
    repeat (len) step_cycle();
    cart_download = 1'b0;
  endtask

  // sweep over and core out of reset
  task automatic await_core_release();
    while (clearing || !core_reset_n) begin
      step_cycle();
    end
  endtask

  task automatic run_episode(input int ep);
    logic [31:0] rnd;
    int          len;
    rnd           = $random(seed);
    rom_size      = rnd[3:0];
    ram_size      = rnd[7:4];
    wram_fill_sel = rnd[9:8];
    aram_fill_sel = rnd[11:10];
    // corner codes for no save ram and masks past 24 bits
    if (ep == 0) begin
      rom_size = 4'd14;
      ram_size = 4'd0;
    end else if (ep == 1) begin
      rom_size = 4'd15;
    end
    len = 10 + int'(rnd[31:16] % 16'd51);
    drive_download(len);
    // restart inside the settle window
    if (ep == 2) begin
      repeat (3) step_cycle();
      drive_download(len);
    end
    await_core_release();
    rnd = $random(seed);
    if (rnd[0]) begin
      core_reset_req = 1'b1;
      repeat (1 + int'(rnd[4:1])) step_cycle();
      core_reset_req = 1'b0;
      await_core_release();
    end
    repeat (2 + int'(rnd[7:5])) step_cycle();
  endtask

  initial begin : stimulus
    int ep;
    seed           = 32'haf2b_714b;
    check_en       = 1'b0;
    reset          = 1'b0;
    cart_download  = 1'b0;
    core_reset_req = 1'b0;
    rom_size       = '0;
    ram_size       = '0;
    wram_fill_sel  = '0;
    aram_fill_sel  = '0;
    step_cycle();
    check_en = 1'b1;
    repeat (4) step_cycle();
    reset = 1'b1;
    repeat (3) step_cycle();
    for (ep = 0; ep < EPISODES; ep++) begin
      run_episode(ep);
    end
    repeat (8) step_cycle();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: verilog.f
rtl/snes_load_pkg.sv
rtl/load_sequencer.sv
rtl/ram_clear.sv
rtl/core_reset_gen.sv
rtl/snes_load_top.sv
dv/snes_load_props.sv
dv/tb_snes_load.sv

// File: Makefile
# Verilator flow for the cartridge load housekeeping block

VERILATOR  ?= verilator
FILELIST   ?= verilog.f
TB_TOP     ?= tb_snes_load
RTL_TOP    ?= snes_load_top
BUILD_DIR  ?= obj_dir
SIM_BIN    ?= sim_snes_load
LINT_FLAGS ?= -Wall
VFLAGS     ?= --timing --assert
SIM_FLAGS  ?=

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) $(SIM_FLAGS) -f $(FILELIST) \
		--top-module $(TB_TOP) -Mdir $(BUILD_DIR) -o $(SIM_BIN)

# a $fatal in the testbench gives a non-zero exit status
sim: $(BUILD_DIR)/$(SIM_BIN)
	./$(BUILD_DIR)/$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
